/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period.
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1; // Released on a falling edge.
	end

endmodule

`default_nettype wire

/* sim/tdc_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tdc_checker (
	input  logic                                              clk,
	input  logic                                              rst_n,
	input  logic                                              rec_valid,
	input  logic [tdc_pkg::CHANNEL_WIDTH-1:0]                 rec_channel,
	input  logic                                              rec_hit,
	input  logic [tdc_pkg::STAMP_WIDTH-1:0]                   rec_stamp,
	input  logic                                              busy,
	input  logic                                              armed,
	input  int                                                entry,
	input  logic [tdc_pkg::CHANNELS-1:0]                      exp_hit,
	input  logic [tdc_pkg::CHANNELS*tdc_pkg::STAMP_WIDTH-1:0] exp_stamps,
	input  logic                                              report,
	output int                                                entries_done,
	output int                                                error_count
);

	localparam int RECORD_LIMIT = 170; // Cycles from arming to the last record.

	int records_seen;
	int wait_cycles;
	int entry_errors;
	int passed = 0;
	int failed = 0;
	bit active = 1'b0;
	bit busy_pending = 1'b0;
	bit reset_checked = 1'b0;

	initial
	begin
		entries_done = 0;
		error_count  = 0;
	end

	task automatic compare_field(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("** Error at %0t: %s expected %0d, got %0d (entry %0d)",
				$time, name, expected, actual, entry);
			entry_errors++;
			error_count++;
		end
	endtask

	task automatic finish_entry();
		if (entry_errors == 0)
		begin
			passed++;
			$display("entry %0d: pass, %0d records", entry, records_seen);
		end
		else
		begin
			failed++;
			$display("entry %0d: fail, %0d errors", entry, entry_errors);
		end
		entries_done++;
		active = 1'b0;
	endtask

	// Outputs are sampled on the falling edge, half a cycle after they change.
	always @(negedge clk)
	begin
		if (rst_n && !reset_checked)
		begin
			compare_field("busy", 0, busy); // Idle right after reset.
			compare_field("rec_valid", 0, rec_valid);
			reset_checked = 1'b1;
		end
		if (rst_n)
		begin
			if (!active && armed && entry == entries_done)
			begin
				active       = 1'b1;
				records_seen = 0;
				wait_cycles  = 0;
				entry_errors = 0;
			end
			if (busy_pending)
			begin
				compare_field("busy", 0, busy); // Drops after the last record.
				busy_pending = 1'b0;
				finish_entry();
			end
			if (rec_valid)
			begin
				if (!active || records_seen >= tdc_pkg::CHANNELS)
				begin
					$display("entry %0d: a record for channel %0d came when none was due",
						entry, rec_channel);
					entry_errors++;
					error_count++;
				end
				else
				begin
					compare_field("rec_channel", records_seen, rec_channel);
					compare_field("rec_hit", exp_hit[records_seen], rec_hit);
					compare_field("rec_stamp",
						exp_stamps[records_seen*tdc_pkg::STAMP_WIDTH +: tdc_pkg::STAMP_WIDTH],
						rec_stamp);
					records_seen++;
					if (records_seen == tdc_pkg::CHANNELS)
						busy_pending = 1'b1;
				end
			end
			if (active && !busy_pending)
			begin
				wait_cycles++;
				if (wait_cycles > RECORD_LIMIT)
				begin
					$display("entry %0d: only %0d of %0d records arrived in time",
						entry, records_seen, tdc_pkg::CHANNELS);
					entry_errors++;
					error_count++;
					finish_entry();
				end
			end
		end
	end

	always @(posedge report)
		$display("checked %0d entries: %0d passed, %0d failed, %0d errors",
			entries_done, passed, failed, error_count);

endmodule

`default_nettype wire

/* sim/tdc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tdc_tb;

	localparam int CH              = tdc_pkg::CHANNELS;
	localparam int SW              = tdc_pkg::STAMP_WIDTH;
	localparam int FIXED_ENTRIES   = 6;
	localparam int ENTRIES         = 10;
	localparam int DRIVE_CYCLES    = 152; // Covers the latest second stop.
	localparam int PULSE_CYCLES    = 2;
	localparam int WATCHDOG_CYCLES = 10 + ENTRIES * 200;

	logic                              clk;
	logic                              rst_n;
	logic                              start;
	logic [CH-1:0]                     stop;
	logic                              clear;
	logic                              rec_valid;
	logic [tdc_pkg::CHANNEL_WIDTH-1:0] rec_channel;
	logic                              rec_hit;
	logic [SW-1:0]                     rec_stamp;
	logic                              busy;
	logic                              armed;
	int                                entry;
	logic [CH-1:0]                     exp_hit;
	logic [CH*SW-1:0]                  exp_stamps;
	logic                              report;
	int                                entries_done;
	int                                error_count;

	// One row per measurement.
	logic [CH-1:0]    en_tab        [ENTRIES];
	logic [CH-1:0]    rise_tab      [ENTRIES]; // Stop driven on the rising edge.
	int               k_tab         [ENTRIES][CH]; // Cycles after start.
	int               k2_tab        [ENTRIES][CH]; // Second stop, 0 for none.
	int               restart_tab   [ENTRIES]; // Start again while busy.
	logic [CH-1:0]    exp_hit_tab   [ENTRIES];
	logic [CH*SW-1:0] exp_stamp_tab [ENTRIES];

	tb_clock_gen i_clock_gen (.clk(clk), .rst_n(rst_n));

	tdc_top i_tdc_top (
		.clk(clk), .rst_n(rst_n), .start(start), .stop(stop), .clear(clear),
		.rec_valid(rec_valid), .rec_channel(rec_channel), .rec_hit(rec_hit),
		.rec_stamp(rec_stamp), .busy(busy)
	);

	tdc_checker i_checker (
		.clk(clk), .rst_n(rst_n), .rec_valid(rec_valid), .rec_channel(rec_channel),
		.rec_hit(rec_hit), .rec_stamp(rec_stamp), .busy(busy), .armed(armed),
		.entry(entry), .exp_hit(exp_hit), .exp_stamps(exp_stamps), .report(report),
		.entries_done(entries_done), .error_count(error_count)
	);

	function automatic logic pulse_on(input int k, input int n);
		return (k != 0) && (n >= k) && (n < k + PULSE_CYCLES);
	endfunction

	task automatic set_entry(input int e, input logic [CH-1:0] en, input logic [CH-1:0] rise,
		input int d0, input int d1, input int d2, input int d3, input int restart);
		en_tab[e]      = en;
		rise_tab[e]    = rise;
		k_tab[e][0]    = d0;
		k_tab[e][1]    = d1;
		k_tab[e][2]    = d2;
		k_tab[e][3]    = d3;
		k2_tab[e]      = '{default: 0};
		restart_tab[e] = restart;
	endtask

	task automatic load_table();
		int e;
		int i;
		int stamp;
		set_entry(0, 4'b1111, 4'b0000, 1, 10, 50, 127, 0);
		set_entry(1, 4'b1111, 4'b1111, 1, 20, 64, 127, 0);
		set_entry(2, 4'b1110, 4'b0100, 0, 128, 130, 5, 0); // Missing and late stops.
		set_entry(3, 4'b0111, 4'b0010, 3, 60, 100, 0, 0);
		k2_tab[3][0] = 40;
		k2_tab[3][1] = 70;
		k2_tab[3][2] = 105;
		set_entry(4, 4'b1111, 4'b1010, 2, 31, 90, 126, 20);
		set_entry(5, 4'b1011, 4'b0001, 127, 4, 0, 128, 130); // Restart during readout.
		for (e = FIXED_ENTRIES; e < ENTRIES; e++)
		begin
			restart_tab[e] = ($urandom % 2) ? 8 + $urandom % 120 : 0;
			for (i = 0; i < CH; i++)
			begin
				en_tab[e][i]   = ($urandom % 4) != 0;
				rise_tab[e][i] = $urandom % 2;
				k_tab[e][i]    = 1 + $urandom % 135;
				k2_tab[e][i]   = ($urandom % 2) ? k_tab[e][i] + 5 + $urandom % 10 : 0;
			end
		end
		// The first stop decides, a second one always comes later.
		for (e = 0; e < ENTRIES; e++)
			for (i = 0; i < CH; i++)
			begin
				exp_hit_tab[e][i] = en_tab[e][i] && k_tab[e][i] >= 1 && k_tab[e][i] <= 127;
				stamp = 0;
				if (exp_hit_tab[e][i])
					stamp = 4 * k_tab[e][i] - (rise_tab[e][i] ? 2 : 0);
				exp_stamp_tab[e][i*SW +: SW] = stamp[SW-1:0];
			end
	endtask

	// Start rises at falling edge 0, stops at falling or rising edge k.
	task automatic drive_entry(input int e);
		int n;
		int i;
		logic [CH-1:0] next_stop;
		@(negedge clk);
		start <= 1'b1;
		for (n = 1; n < DRIVE_CYCLES; n++)
		begin
			@(posedge clk);
			next_stop = stop;
			for (i = 0; i < CH; i++)
				if (rise_tab[e][i])
					next_stop[i] = en_tab[e][i]
						& (pulse_on(k_tab[e][i], n) | pulse_on(k2_tab[e][i], n));
			stop <= next_stop;
			@(negedge clk);
			next_stop = stop;
			for (i = 0; i < CH; i++)
				if (!rise_tab[e][i])
					next_stop[i] = en_tab[e][i]
						& (pulse_on(k_tab[e][i], n) | pulse_on(k2_tab[e][i], n));
			stop  <= next_stop;
			start <= (n < PULSE_CYCLES) | pulse_on(restart_tab[e], n);
		end
		@(negedge clk);
		start <= 1'b0;
		stop  <= '0;
	endtask

	initial
	begin
		int seed;
		int discard;
		int e;
		start      = 1'b0;
		stop       = '0;
		clear      = 1'b0;
		armed      = 1'b0;
		entry      = 0;
		exp_hit    = '0;
		exp_stamps = '0;
		report     = 1'b0;
		seed       = 98;
		discard    = $urandom(seed);
		load_table();
		@(posedge rst_n);
		repeat (2) @(negedge clk);
		for (e = 0; e < ENTRIES; e++)
		begin
			@(negedge clk);
			entry      <= e;
			exp_hit    <= exp_hit_tab[e];
			exp_stamps <= exp_stamp_tab[e];
			armed      <= 1'b1;
			drive_entry(e);
			while (entries_done <= e)
				@(posedge clk);
			@(negedge clk);
			armed <= 1'b0;
			repeat (3) @(negedge clk);
		end
		report <= 1'b1;
		@(posedge clk);
		if (error_count == 0 && entries_done == ENTRIES)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: run still going after %0d cycles, entry %0d",
			WATCHDOG_CYCLES, entry);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* source/coarse_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module coarse_counter (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              start_flag,
	input  logic                              clear,
	output tdc_pkg::window_state_e            state,
	output logic                              window_open,
	output logic [tdc_pkg::COARSE_WIDTH-1:0]  count
);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= tdc_pkg::IDLE;
			count <= '0;
		end
		else if (clear)
		begin
			state <= tdc_pkg::IDLE; // Abort any window.
			count <= '0;
		end
		else
		begin
			case (state)
				tdc_pkg::IDLE:
				begin
					if (start_flag)
					begin
						state <= tdc_pkg::OPEN;
						count <= '0; // First open cycle counts zero.
					end
				end
				tdc_pkg::OPEN:
				begin
					if (count == tdc_pkg::COARSE_LAST)
						state <= tdc_pkg::CLOSED;
					else
						count <= count + 1'b1;
				end
				tdc_pkg::CLOSED:
				begin
					state <= tdc_pkg::IDLE;
					count <= '0;
				end
				default:
				begin
					state <= tdc_pkg::IDLE;
					count <= '0;
				end
			endcase
		end
	end

	assign window_open = (state == tdc_pkg::OPEN);

	// The readout relies on a single CLOSED cycle after every full window.
	a_closed_once: assert property (@(posedge clk) disable iff (!rst_n)
		state == tdc_pkg::CLOSED |=> state == tdc_pkg::IDLE);

endmodule

`default_nettype wire

/* source/dual_edge_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_edge_detector (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                line,
	output logic                edge_flag,
	output tdc_pkg::fine_code_e fine
);

	logic pos_meta; // Rising-edge synchronizer.
	logic pos_sync;
	logic pos_prev;
	logic neg_meta; // Falling-edge synchronizer.
	logic neg_sync;
	logic neg_xfer; // Falling path in the rising domain.
	logic neg_prev;
	logic rise_pos;
	logic rise_neg;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pos_meta <= 1'b0;
			pos_sync <= 1'b0;
			pos_prev <= 1'b0;
			neg_xfer <= 1'b0;
			neg_prev <= 1'b0;
		end
		else
		begin
			pos_meta <= line;
			pos_sync <= pos_meta;
			pos_prev <= pos_sync;
			neg_xfer <= neg_sync; // Half-cycle path, already synchronized.
			neg_prev <= neg_xfer;
		end
	end

	always_ff @(negedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			neg_meta <= 1'b0;
			neg_sync <= 1'b0;
		end
		else
		begin
			neg_meta <= line;
			neg_sync <= neg_meta;
		end
	end

	// An edge the falling sampler caught reaches neg_xfer in the same
	// cycle as pos_sync, so both paths line up here.
	assign rise_pos = pos_sync & ~pos_prev;
	assign rise_neg = neg_xfer & ~neg_prev;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			edge_flag <= 1'b0;
			fine      <= tdc_pkg::FINE_ON_TIME;
		end
		else if (edge_flag)
		begin
			edge_flag <= 1'b0; // Holdoff drops the late falling copy.
			fine      <= tdc_pkg::FINE_ON_TIME;
		end
		else
		begin
			edge_flag <= rise_pos | rise_neg;
			if (rise_neg)
				fine <= tdc_pkg::FINE_EARLY; // Falling path wins.
			else
				fine <= tdc_pkg::FINE_ON_TIME;
		end
	end

	a_flag_single: assert property (@(posedge clk) disable iff (!rst_n)
		edge_flag |=> !edge_flag);

endmodule

`default_nettype wire

/* source/hit_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module hit_channel (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              start_flag,
	input  logic                              window_open,
	input  logic                              stop_flag,
	input  tdc_pkg::fine_code_e               fine,
	input  logic [tdc_pkg::COARSE_WIDTH-1:0]  count,
	output logic                              hit,
	output logic [tdc_pkg::STAMP_WIDTH-1:0]   stamp
);

	logic                             stop_q; // Lines the stop up with count k.
	tdc_pkg::fine_code_e              fine_q;
	logic [tdc_pkg::STAMP_WIDTH-1:0]  stamp_next;
	logic                             capture;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			stop_q <= 1'b0;
		else
			stop_q <= stop_flag;
	end

	always_ff @(posedge clk)
	begin
		fine_q <= fine;
	end

	// Coarse count in quarter periods, less the fine code value.
	assign stamp_next = {count, 2'b00}
		- {{(tdc_pkg::STAMP_WIDTH - tdc_pkg::FINE_WIDTH){1'b0}}, fine_q};

	assign capture = window_open & stop_q & ~hit; // First hit only.

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			hit <= 1'b0;
		else if (start_flag)
			hit <= 1'b0; // New measurement.
		else if (capture)
			hit <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (start_flag)
			stamp <= '0;
		else if (capture)
			stamp <= stamp_next;
	end

	// Later stops in the same window must not disturb the stored stamp.
	a_stamp_held: assert property (@(posedge clk) disable iff (!rst_n)
		hit && !start_flag |=> $stable(stamp));

endmodule

`default_nettype wire

/* source/hit_readout.sv */
`timescale 1ns/1ps
`default_nettype none

module hit_readout (
	input  logic                                                clk,
	input  logic                                                rst_n,
	input  tdc_pkg::window_state_e                              state,
	input  logic [tdc_pkg::CHANNELS-1:0]                        hit,
	input  logic [tdc_pkg::CHANNELS*tdc_pkg::STAMP_WIDTH-1:0]   stamps,
	output logic                                                rec_valid,
	output logic [tdc_pkg::CHANNEL_WIDTH-1:0]                   rec_channel,
	output logic                                                rec_hit,
	output logic [tdc_pkg::STAMP_WIDTH-1:0]                     rec_stamp
);

	logic                               walking; // Channels after 0 still pending.
	logic [tdc_pkg::CHANNEL_WIDTH-1:0]  idx;     // Next channel while walking.
	logic                               emit;
	logic [tdc_pkg::CHANNEL_WIDTH-1:0]  sel;
	logic [tdc_pkg::STAMP_WIDTH-1:0]    sel_stamp;

	// CLOSED emits channel 0 directly, the walk covers the rest.
	assign emit      = walking | (state == tdc_pkg::CLOSED);
	assign sel       = walking ? idx : '0;
	assign sel_stamp = stamps[sel * tdc_pkg::STAMP_WIDTH +: tdc_pkg::STAMP_WIDTH];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			walking <= 1'b0;
			idx     <= '0;
		end
		else if (emit)
		begin
			idx     <= sel + 1'b1;
			walking <= (sel != (tdc_pkg::CHANNELS - 1)); // Stop after last.
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rec_valid <= 1'b0;
		else
			rec_valid <= emit;
	end

	always_ff @(posedge clk)
	begin
		if (emit)
		begin
			rec_channel <= sel;
			rec_hit     <= hit[sel];
			if (hit[sel])
				rec_stamp <= sel_stamp;
			else
				rec_stamp <= '0; // No hit reads as zero.
		end
	end

	a_first_channel: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(rec_valid) |-> rec_channel == '0);

	a_channel_order: assert property (@(posedge clk) disable iff (!rst_n)
		rec_valid && $past(rec_valid) |-> rec_channel == $past(rec_channel) + 1'b1);

endmodule

`default_nettype wire

/* source/tdc_pkg.sv */
`default_nettype none

package tdc_pkg;

	localparam int CHANNELS      = 4; // Stop channels.
	localparam int CHANNEL_WIDTH = 2;
	localparam int COARSE_WIDTH  = 7;
	localparam int FINE_WIDTH    = 2;
	localparam int STAMP_WIDTH   = COARSE_WIDTH + 2; // Quarter-period units.

	// Last count of the open window, all ones.
	localparam logic [COARSE_WIDTH-1:0] COARSE_LAST = {COARSE_WIDTH{1'b1}};

	// The code value is the number of quarter periods the edge
	// came before the rising clock edge that reports it.
	typedef enum logic [FINE_WIDTH-1:0] {
		FINE_ON_TIME = 2'b00, // Seen first by the rising sampler.
		FINE_EARLY   = 2'b10  // Seen first by the falling sampler.
	} fine_code_e;

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		OPEN   = 2'b01,
		CLOSED = 2'b10  // One cycle, triggers readout.
	} window_state_e;

endpackage

`default_nettype wire

/* source/tdc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tdc_top (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               start,
	input  logic [tdc_pkg::CHANNELS-1:0]       stop,
	input  logic                               clear,
	output logic                               rec_valid,
	output logic [tdc_pkg::CHANNEL_WIDTH-1:0]  rec_channel,
	output logic                               rec_hit,
	output logic [tdc_pkg::STAMP_WIDTH-1:0]    rec_stamp,
	output logic                               busy
);

	logic                                               start_flag;
	logic                                               start_arm;  // Accepted start.
	logic [tdc_pkg::CHANNELS-1:0]                       stop_flag;
	tdc_pkg::fine_code_e                                stop_fine [tdc_pkg::CHANNELS];
	tdc_pkg::window_state_e                             state;
	logic                                               window_open;
	logic [tdc_pkg::COARSE_WIDTH-1:0]                   count;
	logic [tdc_pkg::CHANNELS-1:0]                       hit;
	logic [tdc_pkg::CHANNELS*tdc_pkg::STAMP_WIDTH-1:0]  stamps;

	// START sets the time origin, its fine code is not needed.
	dual_edge_detector i_start_det (
		.clk       (clk),
		.rst_n     (rst_n),
		.line      (start),
		.edge_flag (start_flag),
		.fine      ()
	);

	assign start_arm = start_flag & ~busy; // Ignore starts until readout ends.

	coarse_counter i_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.start_flag  (start_arm),
		.clear       (clear),
		.state       (state),
		.window_open (window_open),
		.count       (count)
	);

	for (genvar i = 0; i < tdc_pkg::CHANNELS; i++)
	begin : g_chan
		dual_edge_detector i_stop_det (
			.clk       (clk),
			.rst_n     (rst_n),
			.line      (stop[i]),
			.edge_flag (stop_flag[i]),
			.fine      (stop_fine[i])
		);

		hit_channel i_hit (
			.clk         (clk),
			.rst_n       (rst_n),
			.start_flag  (start_arm),
			.window_open (window_open),
			.stop_flag   (stop_flag[i]),
			.fine        (stop_fine[i]),
			.count       (count),
			.hit         (hit[i]),
			.stamp       (stamps[i*tdc_pkg::STAMP_WIDTH +: tdc_pkg::STAMP_WIDTH])
		);
	end

	hit_readout i_readout (
		.clk         (clk),
		.rst_n       (rst_n),
		.state       (state),
		.hit         (hit),
		.stamps      (stamps),
		.rec_valid   (rec_valid),
		.rec_channel (rec_channel),
		.rec_hit     (rec_hit),
		.rec_stamp   (rec_stamp)
	);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			busy <= 1'b0;
		else if (clear)
			busy <= 1'b0;
		else if (start_arm)
			busy <= 1'b1;
		else if (rec_valid && (rec_channel == (tdc_pkg::CHANNELS - 1)))
			busy <= 1'b0; // Last record out.
	end

endmodule

`default_nettype wire

/* vlog.f */
source/tdc_pkg.sv
source/dual_edge_detector.sv
source/coarse_counter.sv
source/hit_channel.sv
source/hit_readout.sv
source/tdc_top.sv
sim/tb_clock_gen.sv
sim/tdc_checker.sv
sim/tdc_tb.sv
